// File: Bender.yml
package:
  name: rip_pseudo_core

sources:
  - hdl/rip_pkg.sv
  - hdl/rip_axi_if.sv
  - hdl/rip_mem_req_if.sv
  - hdl/rip_axi_master.sv
  - hdl/rip_pseudo_core.sv
  - hdl/rip_pseudo_core_wrapper.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_axi_mem.sv
      - verification/tb_checker.sv
      - verification/tb_top.sv

// File: hdl/rip_axi_if.sv
`timescale 1ns/1ps

interface rip_axi_if;
    import rip_pkg::*;

    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [DATA_WIDTH-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    modport master (
        output awaddr, awvalid, input awready,
        output wdata, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready
    );

    modport slave (
        input awaddr, awvalid, output awready,
        input wdata, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

endinterface

// File: hdl/rip_axi_master.sv
`timescale 1ns/1ps

module rip_axi_master (
    input logic          clk,
    input logic          arst_n,
    rip_mem_req_if.slave req,
    rip_axi_if.master    axi
);
    import rip_pkg::*;

    master_state_e         state;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic                  aw_acc;
    logic                  w_acc;

    // a write channel counts as accepted once its valid has dropped or it transfers now.
    assign aw_acc = ~axi.awvalid | axi.awready;
    assign w_acc  = ~axi.wvalid | axi.wready;

    assign axi.awaddr = addr_q;
    assign axi.araddr = addr_q;
    assign axi.wdata  = wdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= M_IDLE;
            axi.awvalid <= 1'b0;
            axi.wvalid  <= 1'b0;
            axi.bready  <= 1'b0;
            axi.arvalid <= 1'b0;
            axi.rready  <= 1'b0;
            req.done    <= 1'b0;
        end else begin
            req.done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (req.valid && req.write) begin
                        axi.awvalid <= 1'b1;
                        axi.wvalid  <= 1'b1;
                        state       <= M_WRITE;
                    end else if (req.valid) begin
                        axi.arvalid <= 1'b1;
                        state       <= M_READ;
                    end
                end
                M_READ: begin
                    if (axi.arvalid && axi.arready) begin
                        axi.arvalid <= 1'b0;
                        axi.rready  <= 1'b1;
                    end
                    if (axi.rready && axi.rvalid) begin
                        axi.rready <= 1'b0;
                        req.done   <= 1'b1;
                        state      <= M_RESP;
                    end
                end
                M_WRITE: begin
                    if (axi.awvalid && axi.awready) begin
                        axi.awvalid <= 1'b0;
                    end
                    if (axi.wvalid && axi.wready) begin
                        axi.wvalid <= 1'b0;
                    end
                    if (!axi.bready && aw_acc && w_acc) begin
                        axi.bready <= 1'b1;
                    end
                    if (axi.bready && axi.bvalid) begin
                        axi.bready <= 1'b0;
                        req.done   <= 1'b1;
                        state      <= M_RESP;
                    end
                end
                // done is high here, so the still-raised valid is not taken again.
                M_RESP: state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_IDLE && req.valid) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
        if (axi.rready && axi.rvalid) begin
            req.rdata <= axi.rdata;
            req.err   <= (axi.rresp != RESP_OKAY);
        end
        if (axi.bready && axi.bvalid) begin
            req.err <= (axi.bresp != RESP_OKAY);
        end
    end

endmodule

// File: hdl/rip_mem_req_if.sv
`timescale 1ns/1ps

interface rip_mem_req_if;
    import rip_pkg::*;

    // the requester holds valid and its payload stable until done.
    logic                  valid;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  done;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;

    modport master (
        output valid, write, addr, wdata,
        input  done, rdata, err
    );

    modport slave (
        input  valid, write, addr, wdata,
        output done, rdata, err
    );

endinterface

// File: hdl/rip_pkg.sv
package rip_pkg;

    // bus and instruction widths.
    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int OP_WIDTH      = 4;
    localparam int OPERAND_WIDTH = 28;

    // AXI response codes.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_HALT  = 4'd0,
        OP_LOAD  = 4'd1,
        OP_ADD   = 4'd2,
        OP_STORE = 4'd3,
        OP_XOR   = 4'd4
    } rip_op_e;

    typedef enum logic [2:0] {
        ST_START,
        ST_FETCH,
        ST_EXEC,
        ST_WRITE,
        ST_DONE,
        ST_FAULT
    } core_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_READ,
        M_WRITE,
        M_RESP
    } master_state_e;

endpackage

// File: hdl/rip_pseudo_core.sv
`timescale 1ns/1ps

module rip_pseudo_core (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [rip_pkg::ADDR_WIDTH-1:0] mem_head,
    output logic [1:0]                     busy,
    rip_mem_req_if.master                  req
);
    import rip_pkg::*;

    core_state_e              state;
    core_state_e              next_state;
    logic [ADDR_WIDTH-1:0]    base;
    logic [OPERAND_WIDTH-1:0] pc;
    logic [DATA_WIDTH-1:0]    ir;
    logic [DATA_WIDTH-1:0]    acc;
    logic                     running;
    logic                     fault;
    rip_op_e                  op;
    logic [OPERAND_WIDTH-1:0] operand;

    // word index to byte address relative to the program base.
    function automatic logic [ADDR_WIDTH-1:0] word_addr(
        input logic [ADDR_WIDTH-1:0]    head,
        input logic [OPERAND_WIDTH-1:0] index
    );
        return head + {{(ADDR_WIDTH-OPERAND_WIDTH-2){1'b0}}, index, 2'b00};
    endfunction

    assign op      = rip_op_e'(ir[DATA_WIDTH-1 -: OP_WIDTH]);
    assign operand = ir[OPERAND_WIDTH-1:0];
    assign busy    = {fault, running};

    always_comb begin
        req.valid = 1'b0;
        req.write = 1'b0;
        req.addr  = word_addr(base, pc);
        req.wdata = acc;
        case (state)
            ST_FETCH: req.valid = 1'b1;
            ST_EXEC: begin
                req.addr  = word_addr(base, operand);
                req.valid = (op == OP_LOAD) || (op == OP_ADD) || (op == OP_XOR);
            end
            ST_WRITE: begin
                req.addr  = word_addr(base, operand);
                req.valid = 1'b1;
                req.write = 1'b1;
            end
            default: req.valid = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_START: next_state = ST_FETCH;
            ST_FETCH: if (req.done) next_state = req.err ? ST_FAULT : ST_EXEC;
            ST_EXEC: begin
                case (op)
                    OP_HALT:  next_state = ST_DONE;
                    OP_STORE: next_state = ST_WRITE;
                    OP_LOAD, OP_ADD, OP_XOR: begin
                        if (req.done) next_state = req.err ? ST_FAULT : ST_FETCH;
                    end
                    default: next_state = ST_FAULT;
                endcase
            end
            ST_WRITE: if (req.done) next_state = req.err ? ST_FAULT : ST_FETCH;
            default: next_state = state;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_START;
            running <= 1'b0;
            fault   <= 1'b0;
        end else begin
            state   <= next_state;
            running <= (next_state == ST_FETCH) || (next_state == ST_EXEC) ||
                       (next_state == ST_WRITE);
            fault   <= fault | (next_state == ST_FAULT);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_START) begin
            base <= mem_head;
            pc   <= '0;
            acc  <= '0;
        end
        if (state == ST_FETCH && req.done) begin
            ir <= req.rdata;
            pc <= pc + 1'b1;
        end
        if (state == ST_EXEC && req.done && !req.err) begin
            case (op)
                OP_LOAD: acc <= req.rdata;
                OP_ADD:  acc <= acc + req.rdata;
                OP_XOR:  acc <= acc ^ req.rdata;
                default: acc <= acc;
            endcase
        end
    end

endmodule

// File: hdl/rip_pseudo_core_wrapper.sv
`timescale 1ns/1ps

module rip_pseudo_core_wrapper (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [rip_pkg::ADDR_WIDTH-1:0] mem_head,
    output logic [1:0]                     busy,
    output logic [rip_pkg::ADDR_WIDTH-1:0] awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [rip_pkg::DATA_WIDTH-1:0] wdata,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready,
    output logic [rip_pkg::ADDR_WIDTH-1:0] araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [rip_pkg::DATA_WIDTH-1:0] rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rvalid,
    output logic                           rready
);

    rip_axi_if     axi_if ();
    rip_mem_req_if mem_req ();

    rip_pseudo_core u_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .mem_head (mem_head),
        .busy     (busy),
        .req      (mem_req)
    );

    rip_axi_master u_master (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .axi    (axi_if)
    );

    // write channels.
    assign awaddr         = axi_if.awaddr;
    assign awvalid        = axi_if.awvalid;
    assign axi_if.awready = awready;
    assign wdata          = axi_if.wdata;
    assign wvalid         = axi_if.wvalid;
    assign axi_if.wready  = wready;
    assign axi_if.bresp   = bresp;
    assign axi_if.bvalid  = bvalid;
    assign bready         = axi_if.bready;

    // read channels.
    assign araddr         = axi_if.araddr;
    assign arvalid        = axi_if.arvalid;
    assign axi_if.arready = arready;
    assign axi_if.rdata   = rdata;
    assign axi_if.rresp   = rresp;
    assign axi_if.rvalid  = rvalid;
    assign rready         = axi_if.rready;

endmodule

// File: src.f
hdl/rip_pkg.sv
hdl/rip_axi_if.sv
hdl/rip_mem_req_if.sv
hdl/rip_axi_master.sv
hdl/rip_pseudo_core.sv
hdl/rip_pseudo_core_wrapper.sv
verification/tb_clock_gen.sv
verification/tb_axi_mem.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: verification/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] err_addr,
    input  logic [1:0]  stall,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import rip_pkg::*;

    logic [31:0] mem [0:1023];
    logic [31:0] aw_q;
    logic [31:0] w_q;
    logic        aw_got;
    logic        w_got;
    integer      seed = 49;

    initial begin
        {awready, wready, arready, bvalid, rvalid, bresp, rresp, rdata} = '0;
    end

    // a ready is withheld whenever a two-bit random draw falls below stall.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            {awready, wready, arready, bvalid, rvalid, aw_got, w_got} <= '0;
        end else begin
            arready <= ($random(seed) & 3) >= stall;
            awready <= !aw_got && (($random(seed) & 3) >= stall);
            wready  <= !w_got && (($random(seed) & 3) >= stall);
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rdata  <= mem[araddr[11:2]];
                rresp  <= (araddr == err_addr) ? RESP_SLVERR : RESP_OKAY;
            end
            if (rvalid && rready) rvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                aw_q   <= awaddr;
            end
            if (wvalid && wready) begin
                w_got <= 1'b1;
                w_q   <= wdata;
            end
            // the response goes out once both address and data are in.
            if (aw_got && w_got) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                bresp  <= (aw_q == err_addr) ? RESP_SLVERR : RESP_OKAY;
                if (aw_q != err_addr) mem[aw_q[11:2]] <= w_q;
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

endmodule

// File: verification/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input logic        clk,
    input logic        arst_n,
    input logic [1:0]  busy,
    input logic [31:0] awaddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata,
    input logic        wvalid,
    input logic        wready,
    input logic        bvalid,
    input logic        bready
);

    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] aw_seen;
    logic [31:0] w_seen;
    logic        exp_fault;
    logic        running_q;
    int          test_id;
    int          err_base;
    int          errors = 0;
    int          tests_done = 0;
    int          tests_failed = 0;

    task automatic begin_test(input int id, input logic fault);
        test_id   = id;
        exp_fault = fault;
        err_base  = errors;
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic add_store(input logic [31:0] addr, input logic [31:0] value);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(value);
    endtask

    task automatic check_store();
        logic [31:0] ea;
        logic [31:0] ed;
        if (exp_addr_q.size() == 0) begin
            $display("test %0d: unexpected store of %h to %h", test_id, w_seen, aw_seen);
            errors++;
        end else begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            if (aw_seen !== ea) begin
                $display("error awaddr expected %h got %h", ea, aw_seen);
                errors++;
            end
            if (w_seen !== ed) begin
                $display("error wdata expected %h got %h", ed, w_seen);
                errors++;
            end
        end
    endtask

    task automatic end_test();
        if (exp_addr_q.size() != 0) begin
            $display("test %0d: %0d expected stores never happened", test_id, exp_addr_q.size());
            errors++;
        end
        if (busy[1] !== exp_fault) begin
            $display("error busy[1] expected %h got %h", exp_fault, busy[1]);
            errors++;
        end
        if (errors == err_base) begin
            $display("test %0d passed", test_id);
        end else begin
            $display("test %0d failed with %0d errors", test_id, errors - err_base);
            tests_failed++;
        end
        tests_done++;
    endtask

    // address and data are captured on their own transfers and compared on the response.
    always @(posedge clk) begin
        if (!arst_n) begin
            if (busy !== 2'b00) begin
                $display("error busy expected %h got %h", 2'b00, busy);
                errors++;
            end
            running_q <= 1'b0;
        end else begin
            running_q <= busy[0];
            if (awvalid && awready) aw_seen <= awaddr;
            if (wvalid && wready) w_seen <= wdata;
            if (bvalid && bready) check_store();
            if (running_q && !busy[0]) end_test();
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import rip_pkg::*;

    localparam int          N_TESTS  = 6;
    localparam int          MAX_PROG = 5;
    localparam logic [31:0] NO_ERR   = 32'hFFFF_FFFC;
    localparam logic [31:0] BAD_OP   = 32'hF000_0000;

    logic        clk;
    logic        arst_n;
    logic [31:0] mem_head;
    logic [1:0]  busy;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] err_addr;
    logic [1:0]  stall;

    // data words sit at operands 8 to 10 and the stores go to operand 12.
    logic [31:0] prog [N_TESTS][MAX_PROG];
    logic [31:0] data [N_TESTS][3];
    logic [31:0] head [N_TESTS];
    logic [31:0] err_at [N_TESTS];
    logic [1:0]  stall_tab [N_TESTS];
    logic        fault_tab [N_TESTS];
    int          n_st [N_TESTS];
    logic [31:0] st_addr [N_TESTS];
    logic [31:0] st_val [N_TESTS];

    tb_clock_gen #(.PERIOD_NS(20)) clk_gen0 (.clk(clk));
    rip_pseudo_core_wrapper dut0 (.*);
    tb_axi_mem mem0 (.*);
    tb_checker chk0 (.*);

    function automatic logic [31:0] instr(input rip_op_e op, input int operand);
        return {op, operand[27:0]};
    endfunction

    task automatic fill_table();
        head      = '{32'h000, 32'h100, 32'h800, 32'h040, 32'h200, 32'h300};
        err_at    = '{NO_ERR, NO_ERR, NO_ERR, NO_ERR, 32'h200 + 4 * 8, NO_ERR};
        stall_tab = '{2'd1, 2'd3, 2'd2, 2'd1, 2'd1, 2'd2};
        fault_tab = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        n_st      = '{1, 1, 1, 0, 0, 1};
        prog[0] = '{instr(OP_LOAD, 8), instr(OP_STORE, 12), instr(OP_HALT, 0), 32'h0, 32'h0};
        prog[1] = '{instr(OP_LOAD, 8), instr(OP_ADD, 9), instr(OP_XOR, 10),
                    instr(OP_STORE, 12), instr(OP_HALT, 0)};
        prog[2] = prog[1];
        prog[3] = '{default: instr(OP_HALT, 0)};
        prog[4] = prog[0];
        prog[5] = '{instr(OP_LOAD, 8), instr(OP_STORE, 12), BAD_OP, instr(OP_STORE, 13),
                    instr(OP_HALT, 0)};
        data[0] = '{32'hCAFE_F00D, 32'h0, 32'h0};
        data[1] = '{32'hFFFF_FFF0, 32'h0000_0025, 32'hA5A5_5A5A};
        data[2] = data[1];
        data[3] = '{default: 32'h0};
        data[4] = '{32'h1234_5678, 32'h0, 32'h0};
        data[5] = '{32'h0BAD_C0DE, 32'h0, 32'h0};
        // each store lands at mem_head plus four times its operand; ADD wraps at 2^32.
        st_addr = '{32'h000 + 4 * 12, 32'h100 + 4 * 12, 32'h800 + 4 * 12, 32'h0, 32'h0,
                    32'h300 + 4 * 12};
        st_val  = '{32'hCAFE_F00D, (32'hFFFF_FFF0 + 32'h0000_0025) ^ 32'hA5A5_5A5A,
                    (32'hFFFF_FFF0 + 32'h0000_0025) ^ 32'hA5A5_5A5A, 32'h0, 32'h0,
                    32'h0BAD_C0DE};
    endtask

    task automatic load_memory(input int t);
        int base;
        base = head[t][11:2];
        for (int i = 0; i < 1024; i++) begin
            mem0.mem[i] = 32'hA500_0000 | i;
        end
        for (int i = 0; i < MAX_PROG; i++) begin
            mem0.mem[base + i] = prog[t][i];
        end
        for (int i = 0; i < 3; i++) begin
            mem0.mem[base + 8 + i] = data[t][i];
        end
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        arst_n   <= 1'b0;
        mem_head <= head[t];
        err_addr <= err_at[t];
        stall    <= stall_tab[t];
        @(posedge clk);
        load_memory(t);
        chk0.begin_test(t, fault_tab[t]);
        if (n_st[t] > 0) chk0.add_store(st_addr[t], st_val[t]);
        repeat (7) @(posedge clk);
        arst_n <= 1'b1;
        wait (chk0.tests_done == t + 1);
        repeat (4) @(posedge clk);
    endtask

    // reset starts high so that its first assertion is a real falling edge.
    initial begin
        arst_n   = 1'b1;
        mem_head = '0;
        err_addr = NO_ERR;
        stall    = 2'd0;
        fill_table();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors",
                 chk0.tests_done, chk0.tests_failed, chk0.errors);
        if (chk0.errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (N_TESTS * MAX_PROG * 40) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", N_TESTS * MAX_PROG * 40);
        $display("Done: errors found");
        $finish;
    end

endmodule
